// File: include/wrRouter_params.svh
`ifndef WR_ROUTER_PARAMS_SVH
`define WR_ROUTER_PARAMS_SVH

// ==========================================================
// Write-data router sizing
// ==========================================================

// Ports on each side of the crossbar
`define WR_NUM_MASTERS 2
`define WR_NUM_SLAVES 2

// Bus widths, strobe is one bit per data byte
`define WR_DATA_WIDTH 32
`define WR_ADDR_WIDTH 16

// Entries in each per-slave order queue
`define WR_ORDER_DEPTH 4

// Open writes a single master may hold at once
`define WR_MAX_OUTSTANDING 3

`endif

// File: rtl/axiBusPkg.sv
`include "wrRouter_params.svh"

// ==========================================================
// Bus-facing payloads of the AW and W channels
// ==========================================================
package axiBusPkg;

	// One AW request
	// Top address bits pick the slave
	typedef struct packed {
		logic [`WR_ADDR_WIDTH-1:0] addr;
		// Beats in burst minus one
		logic [3:0] len;
	} addrReq_t;

	// One W beat
	typedef struct packed {
		logic [`WR_DATA_WIDTH-1:0] data;
		// Byte enables
		logic [`WR_DATA_WIDTH/8-1:0] strb;
		// Final beat of burst
		logic last;
	} wBeat_t;

endpackage

// File: rtl/routePkg.sv
`include "wrRouter_params.svh"

// ==========================================================
// Routing bookkeeping types
// ==========================================================
package routePkg;

	// Keep at least one bit even for a single port
	localparam int masterIdxWidth = (`WR_NUM_MASTERS > 1) ? $clog2(`WR_NUM_MASTERS) : 1;
	localparam int slaveIdxWidth = (`WR_NUM_SLAVES > 1) ? $clog2(`WR_NUM_SLAVES) : 1;

	typedef logic [masterIdxWidth-1:0] masterIdx_t;
	typedef logic [slaveIdxWidth-1:0] slaveIdx_t;

	// One open write as seen by a slave's order queue
	typedef struct packed {
		masterIdx_t master;
	} orderEntry_t;

endpackage

// File: rtl/syncFifo.sv
module syncFifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 4,
	// Entries short of full at which nearFull rises
	parameter int nearFullMargin = 1
)
(
	input logic sysClk,
	input logic rstN,

	// Write side
	input logic push,
	input payload_t pushData,

	// Read side, head is visible without a pop
	input logic pop,
	output payload_t popData,

	// Status
	output logic empty,
	output logic full,
	output logic nearFull
);

	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);
	localparam logic [ptrWidth-1:0] lastPtr = ptrWidth'(depth - 1);

	payload_t mem [depth];
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth-1:0] rdPtr;
	logic [cntWidth-1:0] count;

	// Storage array, written on every push
	always_ff @(posedge sysClk)
	begin
		if (push)
			mem[wrPtr] <= pushData;
	end

	// ==========================================================
	// Pointers and occupancy
	// ==========================================================
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			// Wrap explicitly so depth need not be a power of two
			if (push)
				wrPtr <= (wrPtr == lastPtr) ? '0 : wrPtr + 1'b1;
			if (pop)
				rdPtr <= (rdPtr == lastPtr) ? '0 : rdPtr + 1'b1;

			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;   // idle or push with pop
			endcase
		end
	end

	// Show-ahead head of queue
	assign popData = mem[rdPtr];

	assign empty = (count == '0);
	assign full = (count == cntWidth'(depth));

	// Early warning, leaves room for a push already granted
	assign nearFull = (count >= cntWidth'(depth - nearFullMargin));

	// Producer must respect full, consumer must respect empty
	noOverflow : assert property (@(posedge sysClk) disable iff (!rstN) push |-> !full);
	noUnderflow : assert property (@(posedge sysClk) disable iff (!rstN) pop |-> !empty);

endmodule

// File: rtl/wrAddrArbiter.sv
`include "wrRouter_params.svh"

module wrAddrArbiter (
	input logic sysClk,
	input logic rstN,

	// Master AW channels
	input axiBusPkg::addrReq_t [`WR_NUM_MASTERS-1:0] awReq,
	input logic [`WR_NUM_MASTERS-1:0] awValid,
	output logic [`WR_NUM_MASTERS-1:0] awReady,

	// Feedback from the data controller
	input logic [`WR_NUM_SLAVES-1:0] queueNearFull,
	input logic [`WR_NUM_MASTERS-1:0] lastDone,

	// Order-queue push toward the data controller
	output routePkg::orderEntry_t pushEntry,
	output logic [`WR_NUM_SLAVES-1:0] pushSlave
);

	localparam int numMasters = `WR_NUM_MASTERS;
	localparam int numSlaves = `WR_NUM_SLAVES;
	localparam int addrWidth = `WR_ADDR_WIDTH;
	localparam int slaveBits = $bits(routePkg::slaveIdx_t);
	localparam int maxOpen = `WR_MAX_OUTSTANDING;
	localparam int cntWidth = $clog2(maxOpen + 1);

	routePkg::slaveIdx_t [numMasters-1:0] reqSlave;
	logic [numMasters-1:0] eligible;
	logic [numMasters-1:0] accepted;
	logic [cntWidth-1:0] openCount [numMasters];
	routePkg::slaveIdx_t openSlave [numMasters];
	routePkg::masterIdx_t rrPtr;
	routePkg::masterIdx_t grantIdx;
	logic grantValid;

	// ==========================================================
	// Slave decode and eligibility
	// ==========================================================
	always_comb
	begin
		for (int m = 0; m < numMasters; m++)
		begin
			reqSlave[m] = awReq[m].addr[addrWidth-1 -: slaveBits];
			// Same-slave rule keeps W order equal to AW order per master
			eligible[m] = awValid[m]
				&& (int'(reqSlave[m]) < numSlaves)
				&& !queueNearFull[reqSlave[m]]
				&& (openCount[m] < cntWidth'(maxOpen))
				&& ((openCount[m] == '0) || (openSlave[m] == reqSlave[m]));
		end
	end

	// Round-robin search starting at rrPtr
	always_comb
	begin
		int idx;
		grantValid = 1'b0;
		grantIdx = '0;
		for (int k = 0; k < numMasters; k++)
		begin
			idx = (int'(rrPtr) + k) % numMasters;
			if (!grantValid && eligible[idx])
			begin
				grantValid = 1'b1;
				grantIdx = routePkg::masterIdx_t'(idx);
			end
		end
	end

	// Grant drives ready and the queue push in the same cycle
	always_comb
	begin
		awReady = '0;
		pushSlave = '0;
		pushEntry.master = grantIdx;
		if (grantValid)
		begin
			awReady[grantIdx] = 1'b1;
			pushSlave[reqSlave[grantIdx]] = 1'b1;
		end
	end

	assign accepted = awValid & awReady;

	// Pointer moves just past the winner
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			rrPtr <= '0;
		else if (grantValid)
			rrPtr <= (int'(grantIdx) == numMasters - 1) ? '0 : grantIdx + 1'b1;
	end

	// ==========================================================
	// Open-write tracking per master
	// ==========================================================
	always_ff @(posedge sysClk)
	begin
		for (int m = 0; m < numMasters; m++)
		begin
			if (!rstN)
			begin
				openCount[m] <= '0;
				openSlave[m] <= '0;
			end
			else
			begin
				case ({accepted[m], lastDone[m]})
					2'b10: openCount[m] <= openCount[m] + 1'b1;
					2'b01: openCount[m] <= openCount[m] - 1'b1;
					default: openCount[m] <= openCount[m];
				endcase
				if (accepted[m])
					openSlave[m] <= reqSlave[m];
			end
		end
	end

	// A last beat always belongs to an address taken earlier
	for (genvar m = 0; m < numMasters; m++)
	begin : genOpenCheck
		noCountUnderflow : assert property (@(posedge sysClk) disable iff (!rstN)
			lastDone[m] |-> (openCount[m] != '0));
	end

endmodule

// File: rtl/wrDataController.sv
`include "wrRouter_params.svh"

module wrDataController (
	input logic sysClk,
	input logic rstN,

	// From the address arbiter
	input routePkg::orderEntry_t pushEntry,
	input logic [`WR_NUM_SLAVES-1:0] pushSlave,
	output logic [`WR_NUM_SLAVES-1:0] queueNearFull,

	// Master W channels
	input axiBusPkg::wBeat_t [`WR_NUM_MASTERS-1:0] wBeat,
	input logic [`WR_NUM_MASTERS-1:0] wValid,
	output logic [`WR_NUM_MASTERS-1:0] wReady,
	output logic [`WR_NUM_MASTERS-1:0] lastDone,

	// Toward the per-slave skid buffers
	output axiBusPkg::wBeat_t [`WR_NUM_SLAVES-1:0] bufBeat,
	output logic [`WR_NUM_SLAVES-1:0] bufValid,
	input logic [`WR_NUM_SLAVES-1:0] bufReady
);

	localparam int numMasters = `WR_NUM_MASTERS;
	localparam int numSlaves = `WR_NUM_SLAVES;
	localparam int orderDepth = `WR_ORDER_DEPTH;

	routePkg::orderEntry_t [numSlaves-1:0] headEntry;
	routePkg::masterIdx_t [numSlaves-1:0] headMaster;
	logic [numSlaves-1:0] queueEmpty;
	logic [numSlaves-1:0] popQueue;
	// Per master, the slaves currently offering it ready
	logic [numSlaves-1:0] readyMat [numMasters];

	// ==========================================================
	// Order queue and data steering per slave
	// ==========================================================
	for (genvar s = 0; s < numSlaves; s++)
	begin : genSlave
		syncFifo #(
			.payload_t(routePkg::orderEntry_t),
			.depth(orderDepth),
			.nearFullMargin(1)
		) orderQueue (
			.sysClk(sysClk),
			.rstN(rstN),
			.push(pushSlave[s]),
			.pushData(pushEntry),
			.pop(popQueue[s]),
			.popData(headEntry[s]),
			.empty(queueEmpty[s]),
			.full(),
			.nearFull(queueNearFull[s])
		);

		// Head entry owns the slave until its last beat
		assign headMaster[s] = headEntry[s].master;
		assign bufBeat[s] = wBeat[headMaster[s]];
		assign bufValid[s] = !queueEmpty[s] && wValid[headMaster[s]];

		// Burst closes when its last beat enters the buffer
		assign popQueue[s] = bufValid[s] && bufReady[s] && bufBeat[s].last;
	end

	// ==========================================================
	// Ready merge back to the masters
	// ==========================================================
	always_comb
	begin
		for (int m = 0; m < numMasters; m++)
		begin
			for (int s = 0; s < numSlaves; s++)
				readyMat[m][s] = !queueEmpty[s] && bufReady[s] && (int'(headMaster[s]) == m);
			wReady[m] = |readyMat[m];
			// Tells the arbiter one open write has finished
			lastDone[m] = wValid[m] && wReady[m] && wBeat[m].last;
		end
	end

	// Arbiter keeps a master's open writes on one slave, so one head at most
	for (genvar m = 0; m < numMasters; m++)
	begin : genReadyCheck
		singleReadySource : assert property (@(posedge sysClk) disable iff (!rstN)
			$onehot0(readyMat[m]));
	end

endmodule

// File: rtl/wrSlaveBuffer.sv
module wrSlaveBuffer (
	input logic sysClk,
	input logic rstN,

	// From the data controller
	input axiBusPkg::wBeat_t inBeat,
	input logic inValid,
	output logic inReady,

	// Slave W channel
	output axiBusPkg::wBeat_t outBeat,
	output logic outValid,
	input logic outReady
);

	logic bufEmpty;
	logic bufFull;

	// Two entries let the upstream side run one beat past a slave stall
	syncFifo #(
		.payload_t(axiBusPkg::wBeat_t),
		.depth(2),
		.nearFullMargin(1)
	) skidQueue (
		.sysClk(sysClk),
		.rstN(rstN),
		.push(inValid && inReady),
		.pushData(inBeat),
		.pop(outValid && outReady),
		.popData(outBeat),
		.empty(bufEmpty),
		.full(bufFull),
		.nearFull()
	);

	// Ready toward masters depends on buffer state only, not on slvReady
	assign inReady = !bufFull;
	assign outValid = !bufEmpty;

	// Stalled beat must hold on the slave port
	stableWhileStalled : assert property (@(posedge sysClk) disable iff (!rstN)
		(outValid && !outReady) |=> (outValid && $stable(outBeat)));

endmodule

// File: rtl/wrDataRouter.sv
`include "wrRouter_params.svh"

module wrDataRouter (
	input logic sysClk,
	input logic rstN,

	// ==========================================================
	// Master side
	// ==========================================================
	input axiBusPkg::addrReq_t [`WR_NUM_MASTERS-1:0] awReq,
	input logic [`WR_NUM_MASTERS-1:0] awValid,
	output logic [`WR_NUM_MASTERS-1:0] awReady,
	input axiBusPkg::wBeat_t [`WR_NUM_MASTERS-1:0] wBeat,
	input logic [`WR_NUM_MASTERS-1:0] wValid,
	output logic [`WR_NUM_MASTERS-1:0] wReady,

	// ==========================================================
	// Slave side
	// ==========================================================
	output axiBusPkg::wBeat_t [`WR_NUM_SLAVES-1:0] slvBeat,
	output logic [`WR_NUM_SLAVES-1:0] slvValid,
	input logic [`WR_NUM_SLAVES-1:0] slvReady
);

	localparam int numMasters = `WR_NUM_MASTERS;
	localparam int numSlaves = `WR_NUM_SLAVES;

	// Arbiter to controller
	routePkg::orderEntry_t pushEntry;
	logic [numSlaves-1:0] pushSlave;
	// Controller back to arbiter
	logic [numSlaves-1:0] queueNearFull;
	logic [numMasters-1:0] lastDone;
	// Controller to skid buffers
	axiBusPkg::wBeat_t [numSlaves-1:0] bufBeat;
	logic [numSlaves-1:0] bufValid;
	logic [numSlaves-1:0] bufReady;

	// Grants addresses and records write order per slave
	wrAddrArbiter addrArb (
		.sysClk(sysClk),
		.rstN(rstN),
		.awReq(awReq),
		.awValid(awValid),
		.awReady(awReady),
		.queueNearFull(queueNearFull),
		.lastDone(lastDone),
		.pushEntry(pushEntry),
		.pushSlave(pushSlave)
	);

	// Steers W beats of the head master to each slave
	wrDataController dataCtrl (
		.sysClk(sysClk),
		.rstN(rstN),
		.pushEntry(pushEntry),
		.pushSlave(pushSlave),
		.queueNearFull(queueNearFull),
		.wBeat(wBeat),
		.wValid(wValid),
		.wReady(wReady),
		.lastDone(lastDone),
		.bufBeat(bufBeat),
		.bufValid(bufValid),
		.bufReady(bufReady)
	);

	// Registered output stage per slave
	for (genvar s = 0; s < numSlaves; s++)
	begin : genSlaveBuf
		wrSlaveBuffer slvBuf (
			.sysClk(sysClk),
			.rstN(rstN),
			.inBeat(bufBeat[s]),
			.inValid(bufValid[s]),
			.inReady(bufReady[s]),
			.outBeat(slvBeat[s]),
			.outValid(slvValid[s]),
			.outReady(slvReady[s])
		);
	end

endmodule

// File: test/wrDataRouterTb.sv
`include "wrRouter_params.svh"

module wrDataRouterTb;

	localparam int numMasters = `WR_NUM_MASTERS;
	localparam int numSlaves = `WR_NUM_SLAVES;
	localparam int dataWidth = `WR_DATA_WIDTH;
	localparam int addrWidth = `WR_ADDR_WIDTH;
	localparam int clkPeriod = 4;
	localparam int numRows = 14;
	// Rows from here on are single-beat probes sent after the traffic drains
	localparam int numMain = 12;

	// One table row, expSlave is the slave named by the top address bit
	typedef struct packed {
		routePkg::masterIdx_t master;
		logic [addrWidth-1:0] addr;
		logic [4:0] beats;
		logic [dataWidth-1:0] seed;
		routePkg::slaveIdx_t expSlave;
	} txnRow_t;

	logic sysClk;
	logic rstN;
	axiBusPkg::addrReq_t [numMasters-1:0] awReq;
	logic [numMasters-1:0] awValid;
	logic [numMasters-1:0] awReady;
	axiBusPkg::wBeat_t [numMasters-1:0] wBeat;
	logic [numMasters-1:0] wValid;
	logic [numMasters-1:0] wReady;
	axiBusPkg::wBeat_t [numSlaves-1:0] slvBeat;
	logic [numSlaves-1:0] slvValid;
	logic [numSlaves-1:0] slvReady;

	txnRow_t txnTable [numRows];
	bit tableLoaded;
	// Expected beats per slave, in address handshake order
	axiBusPkg::wBeat_t expQ [numSlaves][$];
	int expRd [numSlaves];
	int addrCount [numSlaves];
	int lastCount [numSlaves];

	wrDataRouter UUT (.*);

	initial
	begin
		sysClk = 1'b0;
		forever #(clkPeriod / 2) sysClk = ~sysClk;
	end

	// ==========================================================
	// Compare tasks and table helpers
	// ==========================================================
	task automatic stopRun();
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkBeat(string name, axiBusPkg::wBeat_t expected,
		axiBusPkg::wBeat_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkSlave(string name, routePkg::slaveIdx_t expected,
		routePkg::slaveIdx_t actual);
		if (actual !== expected)
		begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stopRun();
		end
	endtask

	task automatic checkCount(string name, int expected, int actual);
		if (actual != expected)
		begin
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
			stopRun();
		end
	endtask

	function automatic void setRow(int idx, int master, int addr, int beats,
		logic [dataWidth-1:0] seed, int slave);
		txnTable[idx].master = routePkg::masterIdx_t'(master);
		txnTable[idx].addr = addrWidth'(addr);
		txnTable[idx].beats = 5'(beats);
		txnTable[idx].seed = seed;
		txnTable[idx].expSlave = routePkg::slaveIdx_t'(slave);
	endfunction

	function automatic void loadTable();
		// Columns: row, master, address, beats, data seed, expected slave
		setRow(0, 0, 'h0010, 1, 32'h1000_0000, 0);
		setRow(1, 1, 'h8020, 4, 32'h2000_0000, 1);
		setRow(2, 0, 'h0030, 3, 32'h3000_0000, 0);
		setRow(3, 1, 'h8040, 1, 32'h4000_0000, 1);
		setRow(4, 0, 'h8050, 2, 32'h5000_0000, 1);
		setRow(5, 1, 'h0060, 4, 32'h6000_0000, 0);
		setRow(6, 0, 'h0070, 1, 32'h7000_0000, 0);
		setRow(7, 1, 'h0080, 2, 32'h8000_0000, 0);
		setRow(8, 0, 'h8090, 4, 32'h9000_0000, 1);
		setRow(9, 1, 'h80A0, 3, 32'hA000_0000, 1);
		setRow(10, 0, 'h00B0, 2, 32'hB000_0000, 0);
		setRow(11, 1, 'h00C0, 1, 32'hC000_0000, 0);
		// Probes, one per master
		setRow(12, 0, 'h80D0, 1, 32'hD000_0000, 1);
		setRow(13, 1, 'h00E0, 1, 32'hE000_0000, 0);
	endfunction

	// Data counts up from the seed, all bytes enabled
	function automatic axiBusPkg::wBeat_t makeBeat(int row, int num);
		axiBusPkg::wBeat_t beat;
		beat.data = txnTable[row].seed + dataWidth'(num);
		beat.strb = '1;
		beat.last = (num == int'(txnTable[row].beats) - 1);
		return beat;
	endfunction

	function automatic int findRow(int master, logic [addrWidth-1:0] addr);
		for (int r = 0; r < numRows; r++)
			if (int'(txnTable[r].master) == master && txnTable[r].addr == addr)
				return r;
		return -1;
	endfunction

	// Row whose data range holds this value
	function automatic int rowOfData(logic [dataWidth-1:0] data);
		for (int r = 0; r < numRows; r++)
			if (data >= txnTable[r].seed && data < txnTable[r].seed + dataWidth'(txnTable[r].beats))
				return r;
		return -1;
	endfunction

	function automatic int nextRow(int master, int from, int last);
		for (int r = from; r <= last; r++)
			if (int'(txnTable[r].master) == master)
				return r;
		return last + 1;
	endfunction

	function automatic int rowsForSlave(int slave);
		int n;
		n = 0;
		for (int r = 0; r < numRows; r++)
			if (int'(txnTable[r].expSlave) == slave)
				n++;
		return n;
	endfunction

	task automatic waitDrained();
		bit done;
		done = 1'b0;
		while (!done)
		begin
			@(posedge sysClk);
			done = 1'b1;
			for (int s = 0; s < numSlaves; s++)
				if (expRd[s] != expQ[s].size())
					done = 1'b0;
		end
	endtask

	// ==========================================================
	// Master drivers, AW and W run independently per master
	// ==========================================================
	task automatic runTable(int first, int last, bit probe);
		int awPos [numMasters];
		int wPos [numMasters];
		int beatNum [numMasters];
		logic [numMasters-1:0] awFire;
		logic [numMasters-1:0] wFire;
		axiBusPkg::addrReq_t req;
		bit busy;
		for (int m = 0; m < numMasters; m++)
		begin
			awPos[m] = nextRow(m, first, last);
			wPos[m] = awPos[m];
			beatNum[m] = 0;
		end
		busy = 1'b1;
		@(posedge sysClk);
		#1;
		while (busy)
		begin
			// Probes get no valid gaps
			for (int m = 0; m < numMasters; m++)
			begin
				if (!awValid[m] && awPos[m] <= last && (probe || $urandom_range(3) != 0))
				begin
					req.addr = txnTable[awPos[m]].addr;
					req.len = 4'(txnTable[awPos[m]].beats - 1);
					awReq[m] = req;
					awValid[m] = 1'b1;
				end
				if (!wValid[m] && wPos[m] <= last && (probe || $urandom_range(3) != 0))
				begin
					wBeat[m] = makeBeat(wPos[m], beatNum[m]);
					wValid[m] = 1'b1;
				end
			end
			@(negedge sysClk);
			awFire = awValid & awReady;
			wFire = wValid & wReady;
			for (int m = 0; m < numMasters; m++)
				if (probe && awValid[m])
					checkCount($sformatf("awReady of master %0d after table", m), 1,
						int'(awReady[m]));
			@(posedge sysClk);
			#1;
			busy = 1'b0;
			for (int m = 0; m < numMasters; m++)
			begin
				if (awFire[m])
				begin
					awValid[m] = 1'b0;
					awPos[m] = nextRow(m, awPos[m] + 1, last);
				end
				if (wFire[m])
				begin
					wValid[m] = 1'b0;
					beatNum[m]++;
					if (beatNum[m] == int'(txnTable[wPos[m]].beats))
					begin
						beatNum[m] = 0;
						wPos[m] = nextRow(m, wPos[m] + 1, last);
					end
				end
				if (wPos[m] <= last)
					busy = 1'b1;
			end
		end
	endtask

	// ==========================================================
	// Slave models and port monitor
	// ==========================================================
	initial
	begin
		int row;
		int dst;
		logic [numSlaves-1:0] stalled;
		axiBusPkg::wBeat_t heldBeat [numSlaves];
		slvReady = '0;
		stalled = '0;
		for (int s = 0; s < numSlaves; s++)
		begin
			expRd[s] = 0;
			addrCount[s] = 0;
			lastCount[s] = 0;
		end
		wait (rstN);
		forever
		begin
			@(negedge sysClk);
			// Accepted addresses extend the expected stream of their slave
			for (int m = 0; m < numMasters; m++)
				if (awValid[m] && awReady[m])
				begin
					row = findRow(m, awReq[m].addr);
					if (row < 0)
					begin
						$display("Master %0d had an address accepted that is not in the table", m);
						stopRun();
					end
					dst = int'(txnTable[row].expSlave);
					for (int b = 0; b < int'(txnTable[row].beats); b++)
						expQ[dst].push_back(makeBeat(row, b));
					addrCount[dst]++;
				end
			for (int s = 0; s < numSlaves; s++)
			begin
				// A stalled beat holds valid and payload
				if (stalled[s])
				begin
					checkCount($sformatf("slave %0d valid under stall", s), 1, int'(slvValid[s]));
					checkBeat($sformatf("slave %0d beat under stall", s), heldBeat[s], slvBeat[s]);
				end
				if (slvValid[s] && slvReady[s])
				begin
					if (expRd[s] >= expQ[s].size())
					begin
						$display("Slave %0d received a beat that no accepted address asked for", s);
						stopRun();
					end
					row = rowOfData(slvBeat[s].data);
					if (row >= 0)
						checkSlave($sformatf("row %0d destination", row), txnTable[row].expSlave,
							routePkg::slaveIdx_t'(s));
					checkBeat($sformatf("slave %0d beat %0d", s, expRd[s]), expQ[s][expRd[s]],
						slvBeat[s]);
					if (slvBeat[s].last)
						lastCount[s]++;
					expRd[s]++;
				end
				stalled[s] = slvValid[s] && !slvReady[s];
				heldBeat[s] = slvBeat[s];
			end
			@(posedge sysClk);
			#1;
			// Ready low about one cycle in four
			for (int s = 0; s < numSlaves; s++)
				slvReady[s] = ($urandom_range(3) != 0);
		end
	end

	// Budget of 40 cycles per beat in the table
	initial
	begin
		int totalBeats;
		wait (tableLoaded);
		totalBeats = 0;
		for (int r = 0; r < numRows; r++)
			totalBeats += int'(txnTable[r].beats);
		#(totalBeats * 40 * clkPeriod);
		$display("Watchdog expired before all beats reached the slaves");
		stopRun();
	end

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial
	begin
		rstN = 1'b0;
		awReq = '0;
		awValid = '0;
		wBeat = '0;
		wValid = '0;
		void'($urandom(19));
		loadTable();
		tableLoaded = 1'b1;
		@(posedge sysClk);
		@(negedge sysClk);
		checkCount("slvValid in reset", 0, int'(slvValid));
		checkCount("wReady in reset", 0, int'(wReady));
		@(posedge sysClk);
		#1;
		rstN = 1'b1;
		@(negedge sysClk);
		checkCount("slvValid after reset", 0, int'(slvValid));
		checkCount("wReady after reset", 0, int'(wReady));
		runTable(0, numMain - 1, 1'b0);
		waitDrained();
		// Each probe address must be granted in its first cycle
		for (int r = numMain; r < numRows; r++)
		begin
			runTable(r, r, 1'b1);
			waitDrained();
		end
		for (int s = 0; s < numSlaves; s++)
		begin
			checkCount($sformatf("addresses to slave %0d", s), rowsForSlave(s), addrCount[s]);
			checkCount($sformatf("last beats at slave %0d", s), addrCount[s], lastCount[s]);
		end
		$display("all tests passed");
		$finish;
	end

endmodule

// File: project.f
+incdir+include
rtl/axiBusPkg.sv
rtl/routePkg.sv
rtl/syncFifo.sv
rtl/wrAddrArbiter.sv
rtl/wrDataController.sv
rtl/wrSlaveBuffer.sv
rtl/wrDataRouter.sv
test/wrDataRouterTb.sv

// File: Makefile
TOP = wrDataRouterTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
